//--- bench/tb_rv_exec.sv
`timescale 1ns/10ps
`include "rv_config.svh"

module tb_rv_exec;
    import rv_isa_pkg::*;

    localparam int CLK_PERIOD  = 20;
    localparam int MAX_GAP     = 3;
    localparam int N_ARITH     = 80;
    localparam int N_WORD      = 40;
    localparam int N_X0        = 24; // pairs of x0 write and x0 read
    localparam int N_STORE     = 60;
    localparam int N_CHAIN     = 32;
    localparam int N_ALL       = 14 + N_ARITH + N_WORD + 2 * N_X0 + N_STORE + N_CHAIN;
    localparam int WATCHDOG_NS = (N_ALL * (MAX_GAP + 1) + 100) * CLK_PERIOD;

    logic                       clk = 1'b0;
    logic                       rst_n;
    logic                       instr_valid;
    instr_u                     instr;
    logic                       wb_valid;
    logic [`REG_ADDR_WIDTH-1:0] wb_rd;
    logic [`XLEN-1:0]           wb_data;
    logic                       st_valid;
    logic [`XLEN-1:0]           st_addr;
    logic [`XLEN-1:0]           st_data;
    logic [`XLEN/8-1:0]         st_mask;

    logic [`XLEN-1:0] model_regs [`REG_COUNT];
    logic [31:0]      lfsr = 32'd34;
    int               cycle = 0;
    int               checks = 0;
    int               errors = 0;
    int               mark_chk = 0;
    int               mark_err = 0;
    int               arith_kinds [7] = '{0, 1, 3, 4, 7, 8, 9}; // lui addi add sub and or xor
    int               word_kinds [3] = '{2, 5, 6};              // addiw addw subw

    // expected strobes, oldest first
    bit                         exp_st [$];
    logic [`REG_ADDR_WIDTH-1:0] exp_rd [$];
    logic [`XLEN-1:0]           exp_data [$];
    logic [`XLEN-1:0]           exp_addr [$];
    logic [`XLEN/8-1:0]         exp_mask [$];
    int                         exp_due [$];

    rv_exec_top i_rv_exec_top (
        .clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .instr(instr),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data),
        .st_valid(st_valid), .st_addr(st_addr), .st_data(st_data), .st_mask(st_mask)
    );

    always #(CLK_PERIOD/2) clk = ~clk;
    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[62:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD000_0001) : (lfsr >> 1); // galois step
        end
        return v;
    endfunction

    function automatic int rand_below(input int n);
        logic [63:0] v;
        v = rand_bits(8);
        return int'(v[7:0]) % n;
    endfunction

    function automatic logic [19:0] rand_imm();
        logic [63:0] v;
        v = rand_bits(20);
        return v[19:0];
    endfunction

    function automatic logic [4:0] pick_reg();
        logic [63:0] v;
        v = rand_bits(3);
        if (v[2:0] == 3'd0) begin
            v = rand_bits(5); // now and then the whole register range
        end else begin
            v = rand_bits(3);
        end
        return v[4:0];
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    // kind: 0 lui, 1 addi, 2 addiw, 3 add, 4 sub, 5 addw, 6 subw, 7 and, 8 or, 9 xor,
    // 10..13 sb sh sw sd
    task automatic issue(input int kind, input logic [4:0] rd, input logic [4:0] rs1,
                         input logic [4:0] rs2, input logic [19:0] imm);
        instr_u           w;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] v;
        logic [`XLEN-1:0] ea;
        logic [`XLEN-1:0] sdata;
        logic [7:0]       smask;
        int               lane;
        a     = model_regs[rs1];
        b     = model_regs[rs2];
        w     = '0;
        v     = '0;
        ea    = '0;
        sdata = '0;
        smask = '0;
        if (kind == 0) begin
            w.u.opcode = OPC_LUI;
            w.u.rd     = rd;
            w.u.imm    = imm;
            v          = {{32{imm[19]}}, imm, 12'b0};
        end else if (kind <= 2) begin
            w.i.opcode = (kind == 1) ? OPC_OP_IMM : OPC_OP_IMM_32;
            w.i.funct3 = F3_ADD_SUB;
            w.i.rd     = rd;
            w.i.rs1    = rs1;
            w.i.imm    = imm[11:0];
            v          = a + {{52{imm[11]}}, imm[11:0]};
        end else if (kind <= 9) begin
            w.r.opcode = (kind == 5 || kind == 6) ? OPC_OP_32 : OPC_OP;
            w.r.funct7 = (kind == 4 || kind == 6) ? F7_SUB : F7_BASE;
            w.r.funct3 = (kind == 7) ? F3_AND : (kind == 8) ? F3_OR :
                         (kind == 9) ? F3_XOR : F3_ADD_SUB;
            w.r.rd     = rd;
            w.r.rs1    = rs1;
            w.r.rs2    = rs2;
            v = (kind == 4 || kind == 6) ? a - b : (kind == 7) ? a & b :
                (kind == 8) ? a | b : (kind == 9) ? a ^ b : a + b;
        end else begin
            w.s.opcode = OPC_STORE;
            w.s.funct3 = 3'(kind - 10);
            w.s.rs1    = rs1;
            w.s.rs2    = rs2;
            w.s.imm_hi = imm[11:5];
            w.s.imm_lo = imm[4:0];
            ea         = a + {{52{imm[11]}}, imm[11:0]};
            for (int k = 0; k < (1 << (kind - 10)); k++) begin
                lane = int'(ea[2:0]) + k; // bytes past lane 7 are dropped
                if (lane < 8) begin
                    smask[lane]        = 1'b1;
                    sdata[lane*8 +: 8] = b[k*8 +: 8];
                end
            end
        end
        if (kind == 2 || kind == 5 || kind == 6) begin
            v = {{32{v[31]}}, v[31:0]};
        end
        if (kind < 10 && rd != 5'd0) begin
            model_regs[rd] = v;
        end
        exp_st.push_back(kind >= 10);
        exp_rd.push_back(rd);
        exp_data.push_back((kind >= 10) ? sdata : v);
        exp_addr.push_back({ea[63:3], 3'b000});
        exp_mask.push_back(smask);
        exp_due.push_back(cycle + 2);
        instr_valid = 1'b1;
        instr       = w;
        @(negedge clk);
        instr_valid = 1'b0;
    endtask

    task automatic idle_gap();
        repeat (rand_below(MAX_GAP + 1)) @(negedge clk);
    endtask

    task automatic finish_test(input string name);
        while (exp_due.size() > 0) begin
            @(negedge clk);
        end
        $display("test %-20s %4d checks, %0d errors", name, checks - mark_chk,
                 errors - mark_err);
        mark_chk = checks;
        mark_err = errors;
    endtask

    // outputs are compared at the falling edge, away from the rising edge updates
    always @(negedge clk) begin
        if (rst_n) begin
            if (exp_due.size() > 0 && exp_due[0] == cycle) begin
                check_value("wb_valid", 64'(wb_valid), 64'(!exp_st[0]));
                check_value("st_valid", 64'(st_valid), 64'(exp_st[0]));
                if (exp_st[0]) begin
                    check_value("st_addr", st_addr, exp_addr[0]);
                    check_value("st_mask", 64'(st_mask), 64'(exp_mask[0]));
                    check_value("st_data", st_data, exp_data[0]);
                end else begin
                    check_value("wb_rd", 64'(wb_rd), 64'(exp_rd[0]));
                    check_value("wb_data", wb_data, exp_data[0]);
                end
                void'(exp_st.pop_front());
                void'(exp_rd.pop_front());
                void'(exp_data.pop_front());
                void'(exp_addr.pop_front());
                void'(exp_mask.pop_front());
                void'(exp_due.pop_front());
            end else if (wb_valid || st_valid) begin
                errors++;
                $display("ERROR t=%0t: DUT raised a strobe that no instruction expects", $time);
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: run not finished after %0d ns, strobes went missing", WATCHDOG_NS);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        logic [4:0] prev;
        logic [4:0] dst;
        for (int r = 0; r < `REG_COUNT; r++) begin
            model_regs[r] = '0;
        end
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        repeat (20) begin
            @(negedge clk);
            check_value("wb_valid", 64'(wb_valid), 64'd0);
            check_value("st_valid", 64'(st_valid), 64'd0);
        end
        finish_test("idle after reset");

        for (int r = 1; r < 8; r++) begin // full 64-bit values in x1..x7
            issue(0, 5'(r), 5'd0, 5'd0, rand_imm());
            idle_gap();
            issue(1, 5'(r), 5'(r), 5'd0, rand_imm());
            idle_gap();
        end
        repeat (N_ARITH) begin
            issue(arith_kinds[rand_below(7)], pick_reg(), pick_reg(), pick_reg(), rand_imm());
            idle_gap();
        end
        finish_test("64-bit arith/logic");

        repeat (N_WORD) begin
            issue(word_kinds[rand_below(3)], pick_reg(), pick_reg(), pick_reg(), rand_imm());
            idle_gap();
        end
        finish_test("word forms");

        repeat (N_X0) begin
            issue(arith_kinds[rand_below(7)], 5'd0, pick_reg(), pick_reg(), rand_imm());
            idle_gap();
            issue(3, pick_reg(), 5'd0, pick_reg(), 20'd0); // x0 as an addend
            idle_gap();
        end
        finish_test("x0 writes");

        repeat (N_STORE) begin
            issue(10 + rand_below(4), 5'd0, pick_reg(), pick_reg(), rand_imm());
            idle_gap();
        end
        finish_test("stores");

        prev = pick_reg();
        repeat (N_CHAIN) begin // no gap, each reads the register just written
            dst = 5'(1 + rand_below(7));
            issue(1 + rand_below(9), dst, prev, prev, rand_imm());
            prev = dst;
        end
        finish_test("back-to-back chain");

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+hdl
hdl/rv_isa_pkg.sv
hdl/rv_exec_pkg.sv
hdl/instr_decoder.sv
hdl/reg_file.sv
hdl/exec_alu.sv
hdl/retire_unit.sv
hdl/rv_exec_top.sv
bench/tb_rv_exec.sv

//--- hdl/exec_alu.sv
`timescale 1ns/10ps
`include "rv_config.svh"

module exec_alu (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       dec_valid,
    input  rv_exec_pkg::alu_op_e       alu_op,
    input  logic [`REG_ADDR_WIDTH-1:0] rs1,
    input  logic [`REG_ADDR_WIDTH-1:0] rs2,
    input  logic [`REG_ADDR_WIDTH-1:0] rd,
    input  logic [`XLEN-1:0]           imm,
    input  logic                       use_imm,
    input  logic                       is_word,
    input  logic                       is_store,
    input  rv_exec_pkg::st_size_e      st_size,
    output logic [`REG_ADDR_WIDTH-1:0] rd1_addr,
    output logic [`REG_ADDR_WIDTH-1:0] rd2_addr,
    input  logic [`XLEN-1:0]           rd1_data,
    input  logic [`XLEN-1:0]           rd2_data,
    output logic                       wr_en,
    output logic [`REG_ADDR_WIDTH-1:0] wr_addr,
    output logic [`XLEN-1:0]           wr_data,
    output logic                       ex_wb,
    output logic                       ex_st,
    output logic [`REG_ADDR_WIDTH-1:0] ex_rd,
    output logic [`XLEN-1:0]           ex_result,
    output logic [`XLEN-1:0]           ex_st_addr,
    output logic [`XLEN-1:0]           ex_st_src,
    output rv_exec_pkg::st_size_e      ex_st_size
);
    import rv_exec_pkg::*;

    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] raw;
    logic [`XLEN-1:0] result;

    assign rd1_addr = rs1;
    assign rd2_addr = rs2;
    assign op_b     = use_imm ? imm : rd2_data;

    always_comb begin
        case (alu_op)
            ALU_ADD:    raw = rd1_data + op_b;
            ALU_SUB:    raw = rd1_data - op_b;
            ALU_AND:    raw = rd1_data & op_b;
            ALU_OR:     raw = rd1_data | op_b;
            ALU_XOR:    raw = rd1_data ^ op_b;
            ALU_PASS_B: raw = op_b;
            default:    raw = '0;
        endcase
    end

    // W forms keep the low word, sign-extended
    assign result = is_word ? {{(`XLEN-32){raw[31]}}, raw[31:0]} : raw;

    assign ex_wb = dec_valid && !is_store;
    assign ex_st = dec_valid && is_store;

    assign wr_en   = ex_wb;
    assign wr_addr = rd;
    assign wr_data = result;

    assign ex_rd      = rd;
    assign ex_result  = result;
    assign ex_st_addr = rd1_data + imm; // base plus s-type offset
    assign ex_st_src  = rd2_data;
    assign ex_st_size = st_size;

endmodule

//--- hdl/instr_decoder.sv
`timescale 1ns/10ps
`include "rv_config.svh"

module instr_decoder (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       instr_valid,
    input  rv_isa_pkg::instr_u         instr,
    output logic                       dec_valid,
    output rv_exec_pkg::alu_op_e       alu_op,
    output logic [`REG_ADDR_WIDTH-1:0] rs1,
    output logic [`REG_ADDR_WIDTH-1:0] rs2,
    output logic [`REG_ADDR_WIDTH-1:0] rd,
    output logic [`XLEN-1:0]           imm,
    output logic                       use_imm,
    output logic                       is_word,
    output logic                       is_store,
    output rv_exec_pkg::st_size_e      st_size
);
    import rv_isa_pkg::*;
    import rv_exec_pkg::*;

    logic                       legal;
    alu_op_e                    op_n;
    logic [`REG_ADDR_WIDTH-1:0] rs1_n;
    logic [`XLEN-1:0]           imm_n;
    logic                       use_imm_n;
    logic                       is_word_n;
    logic                       is_store_n;
    st_size_e                   size_n;

    always_comb begin
        legal      = 1'b0;
        op_n       = ALU_ADD;
        rs1_n      = instr.r.rs1;
        imm_n      = '0;
        use_imm_n  = 1'b0;
        is_word_n  = 1'b0;
        is_store_n = 1'b0;
        size_n     = ST_DOUBLE;
        case (instr.r.opcode)
            OPC_OP, OPC_OP_32: begin
                is_word_n = (instr.r.opcode == OPC_OP_32);
                if (instr.r.funct3 == F3_ADD_SUB) begin
                    legal = (instr.r.funct7 == F7_BASE) || (instr.r.funct7 == F7_SUB);
                    op_n  = (instr.r.funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
                end else if (!is_word_n && instr.r.funct7 == F7_BASE) begin
                    legal = (instr.r.funct3 == F3_XOR) || (instr.r.funct3 == F3_OR) ||
                            (instr.r.funct3 == F3_AND);
                    case (instr.r.funct3)
                        F3_XOR:  op_n = ALU_XOR;
                        F3_OR:   op_n = ALU_OR;
                        default: op_n = ALU_AND;
                    endcase
                end
            end
            OPC_OP_IMM, OPC_OP_IMM_32: begin
                legal     = (instr.i.funct3 == F3_ADD_SUB); // addi / addiw only
                is_word_n = (instr.i.opcode == OPC_OP_IMM_32);
                use_imm_n = 1'b1;
                imm_n     = {{(`XLEN-12){instr.i.imm[11]}}, instr.i.imm};
            end
            OPC_LUI: begin
                legal     = 1'b1;
                op_n      = ALU_PASS_B;
                rs1_n     = '0;
                use_imm_n = 1'b1;
                imm_n     = {{(`XLEN-32){instr.u.imm[19]}}, instr.u.imm, 12'b0};
            end
            OPC_STORE: begin
                legal      = (instr.s.funct3[2] == 1'b0); // sb, sh, sw, sd
                is_store_n = 1'b1;
                size_n     = st_size_e'(instr.s.funct3[1:0]);
                imm_n      = {{(`XLEN-12){instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
            end
            default: legal = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
            alu_op    <= ALU_ADD;
            rs1       <= '0;
            rs2       <= '0;
            rd        <= '0;
            imm       <= '0;
            use_imm   <= 1'b0;
            is_word   <= 1'b0;
            is_store  <= 1'b0;
            st_size   <= ST_BYTE;
        end else begin
            dec_valid <= instr_valid && legal;
            if (instr_valid) begin // fields held between strobes
                alu_op   <= op_n;
                rs1      <= rs1_n;
                rs2      <= instr.r.rs2;
                rd       <= instr.r.rd;
                imm      <= imm_n;
                use_imm  <= use_imm_n;
                is_word  <= is_word_n;
                is_store <= is_store_n;
                st_size  <= size_n;
            end
        end
    end

endmodule

//--- hdl/reg_file.sv
`timescale 1ns/10ps
`include "rv_config.svh"

module reg_file (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       wr_en,
    input  logic [`REG_ADDR_WIDTH-1:0] wr_addr,
    input  logic [`XLEN-1:0]           wr_data,
    input  logic [`REG_ADDR_WIDTH-1:0] rd1_addr,
    input  logic [`REG_ADDR_WIDTH-1:0] rd2_addr,
    output logic [`XLEN-1:0]           rd1_data,
    output logic [`XLEN-1:0]           rd2_data
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin // x0 is never written
            regs[wr_addr] <= wr_data;
        end
    end

    // reads are combinational, so a value written at an edge is visible right after it
    always_comb begin
        if (rd1_addr == '0) begin
            rd1_data = '0;
        end else begin
            rd1_data = regs[rd1_addr];
        end
    end

    always_comb begin
        if (rd2_addr == '0) begin
            rd2_data = '0;
        end else begin
            rd2_data = regs[rd2_addr];
        end
    end

endmodule

//--- hdl/retire_unit.sv
`timescale 1ns/10ps
`include "rv_config.svh"

module retire_unit (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       ex_wb,
    input  logic                       ex_st,
    input  logic [`REG_ADDR_WIDTH-1:0] ex_rd,
    input  logic [`XLEN-1:0]           ex_result,
    input  logic [`XLEN-1:0]           ex_st_addr,
    input  logic [`XLEN-1:0]           ex_st_src,
    input  rv_exec_pkg::st_size_e      ex_st_size,
    output logic                       wb_valid,
    output logic [`REG_ADDR_WIDTH-1:0] wb_rd,
    output logic [`XLEN-1:0]           wb_data,
    output logic                       st_valid,
    output logic [`XLEN-1:0]           st_addr,
    output logic [`XLEN-1:0]           st_data,
    output logic [`XLEN/8-1:0]         st_mask
);
    import rv_exec_pkg::*;

    logic [2:0]         offset;
    logic [`XLEN/8-1:0] size_mask;
    logic [`XLEN/8-1:0] mask_n;
    logic [`XLEN-1:0]   lane_en;
    logic [`XLEN-1:0]   data_n;

    assign offset = ex_st_addr[2:0];

    always_comb begin
        case (ex_st_size)
            ST_BYTE: size_mask = 'h01;
            ST_HALF: size_mask = 'h03;
            ST_WORD: size_mask = 'h0f;
            default: size_mask = 'hff;
        endcase
    end

    assign mask_n = size_mask << offset;

    // bytes outside the mask are driven as zero
    always_comb begin
        for (int b = 0; b < `XLEN/8; b++) begin
            lane_en[b*8 +: 8] = {8{mask_n[b]}};
        end
    end

    assign data_n = (ex_st_src << {offset, 3'b000}) & lane_en;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
            wb_rd    <= '0;
            wb_data  <= '0;
            st_valid <= 1'b0;
            st_addr  <= '0;
            st_data  <= '0;
            st_mask  <= '0;
        end else begin
            wb_valid <= ex_wb;
            st_valid <= ex_st;
            if (ex_wb) begin
                wb_rd   <= ex_rd;
                wb_data <= ex_result;
            end
            if (ex_st) begin
                st_addr <= {ex_st_addr[`XLEN-1:3], 3'b000}; // doubleword aligned
                st_data <= data_n;
                st_mask <= mask_n;
            end
        end
    end

endmodule

//--- hdl/rv_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// integer register width
`define XLEN 64

// register index width, x0..x31
`define REG_ADDR_WIDTH 5

// number of architectural registers
`define REG_COUNT 32

`endif

//--- hdl/rv_exec_pkg.sv
package rv_exec_pkg;

    // operation applied by the execute stage
    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_PASS_B = 3'd5  // lui
    } alu_op_e;

    // store width, same encoding as funct3[1:0] of the store opcode
    typedef enum logic [1:0] {
        ST_BYTE   = 2'd0,
        ST_HALF   = 2'd1,
        ST_WORD   = 2'd2,
        ST_DOUBLE = 2'd3
    } st_size_e;

endpackage

//--- hdl/rv_exec_top.sv
`timescale 1ns/10ps
`include "rv_config.svh"

module rv_exec_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       instr_valid,
    input  rv_isa_pkg::instr_u         instr,
    output logic                       wb_valid,
    output logic [`REG_ADDR_WIDTH-1:0] wb_rd,
    output logic [`XLEN-1:0]           wb_data,
    output logic                       st_valid,
    output logic [`XLEN-1:0]           st_addr,
    output logic [`XLEN-1:0]           st_data,
    output logic [`XLEN/8-1:0]         st_mask
);
    import rv_exec_pkg::*;

    // decode stage
    logic                       dec_valid;
    alu_op_e                    alu_op;
    logic [`REG_ADDR_WIDTH-1:0] rs1;
    logic [`REG_ADDR_WIDTH-1:0] rs2;
    logic [`REG_ADDR_WIDTH-1:0] rd;
    logic [`XLEN-1:0]           imm;
    logic                       use_imm;
    logic                       is_word;
    logic                       is_store;
    st_size_e                   st_size;

    // register file ports
    logic [`REG_ADDR_WIDTH-1:0] rd1_addr;
    logic [`REG_ADDR_WIDTH-1:0] rd2_addr;
    logic [`XLEN-1:0]           rd1_data;
    logic [`XLEN-1:0]           rd2_data;
    logic                       wr_en;
    logic [`REG_ADDR_WIDTH-1:0] wr_addr;
    logic [`XLEN-1:0]           wr_data;

    // execute results
    logic                       ex_wb;
    logic                       ex_st;
    logic [`REG_ADDR_WIDTH-1:0] ex_rd;
    logic [`XLEN-1:0]           ex_result;
    logic [`XLEN-1:0]           ex_st_addr;
    logic [`XLEN-1:0]           ex_st_src;
    st_size_e                   ex_st_size;

    instr_decoder i_instr_decoder (
        .clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .instr(instr),
        .dec_valid(dec_valid), .alu_op(alu_op), .rs1(rs1), .rs2(rs2), .rd(rd),
        .imm(imm), .use_imm(use_imm), .is_word(is_word), .is_store(is_store),
        .st_size(st_size)
    );

    reg_file i_reg_file (
        .clk(clk), .rst_n(rst_n), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .rd1_addr(rd1_addr), .rd2_addr(rd2_addr), .rd1_data(rd1_data), .rd2_data(rd2_data)
    );

    exec_alu i_exec_alu (
        .clk(clk), .rst_n(rst_n), .dec_valid(dec_valid), .alu_op(alu_op),
        .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .use_imm(use_imm),
        .is_word(is_word), .is_store(is_store), .st_size(st_size),
        .rd1_addr(rd1_addr), .rd2_addr(rd2_addr), .rd1_data(rd1_data), .rd2_data(rd2_data),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .ex_wb(ex_wb), .ex_st(ex_st), .ex_rd(ex_rd), .ex_result(ex_result),
        .ex_st_addr(ex_st_addr), .ex_st_src(ex_st_src), .ex_st_size(ex_st_size)
    );

    retire_unit i_retire_unit (
        .clk(clk), .rst_n(rst_n), .ex_wb(ex_wb), .ex_st(ex_st), .ex_rd(ex_rd),
        .ex_result(ex_result), .ex_st_addr(ex_st_addr), .ex_st_src(ex_st_src),
        .ex_st_size(ex_st_size), .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data),
        .st_valid(st_valid), .st_addr(st_addr), .st_data(st_data), .st_mask(st_mask)
    );

endmodule

//--- hdl/rv_isa_pkg.sv
package rv_isa_pkg;

    // one instruction word, read through the view that its opcode selects
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic [19:0] imm;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
    } instr_u;

    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_LUI       = 7'b0110111;
    localparam logic [6:0] OPC_STORE     = 7'b0100011;

    localparam logic [2:0] F3_ADD_SUB = 3'b000; // also addi, addiw
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_SB      = 3'b000;
    localparam logic [2:0] F3_SH      = 3'b001;
    localparam logic [2:0] F3_SW      = 3'b010;
    localparam logic [2:0] F3_SD      = 3'b011;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

endpackage

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, judge the log
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_rv_exec -o Vtb_rv_exec

./obj_dir/Vtb_rv_exec 2>&1 | tee sim.log

if grep -q "Testbench failed" sim.log; then
    echo "run_sim: simulation reported failure, see sim.log"
    exit 1
fi
if ! grep -q "Testbench passed" sim.log; then
    echo "run_sim: simulation ended without a result, see sim.log"
    exit 1
fi
echo "run_sim: simulation ok"
